/* common/loader_cfg.svh */
/*
 * CBM-II memory loader constants
 * Image bases, length limits, BASIC pointer offsets and erase areas
 */
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// ==============================
// ROM image bases
// ==============================
`define LDR_ROM_P500_BASE   25'h102_0000
`define LDR_ROM_B6X0_BASE   25'h100_0000
`define LDR_ROM_B7X0_BASE   25'h101_0000
`define LDR_EXT_BASE_2000   25'h103_2000
`define LDR_EXT_BASE_4000   25'h103_4000
`define LDR_EXT_BASE_6000   25'h103_6000

// Image length limits in host bytes
`define LDR_SYS_ROM_LIMIT   25'h000_B000
`define LDR_EXT_ROM_LIMIT   25'h000_2000

// ==============================
// Zero page and BASIC pointers
// ==============================
`define LDR_ZP_BASE         25'h00F_0000
`define LDR_PTR_TXTTAB      8'h2D
`define LDR_PTR_TXTEND      8'h2F

// Video RAM erase area, segment 15
`define LDR_VRAM_LO_END     25'h00F_0FFF
`define LDR_VRAM_HI_BASE    25'h00F_D000
`define LDR_VRAM_HI_END     25'h00F_D7FF

// Cycles between two erase writes
`define LDR_ERASE_GAP       32

`endif

/* common/mem_pkg.sv */
/*
 * Memory port types of the CBM-II loader
 * Addresses, data, load targets, write requests and engine state
 */
package mem_pkg;

	// ==============================
	// Address and data
	// ==============================
	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  mem_byte_t;
	typedef logic [24:0] host_addr_t;

	// What the current host download is
	typedef enum logic [2:0] {
		TGT_NONE    = 3'd0,
		TGT_P500    = 3'd1,
		TGT_B6X0    = 3'd2,
		TGT_B7X0    = 3'd3,
		TGT_EXT2000 = 3'd4,
		TGT_EXT4000 = 3'd5,
		TGT_EXT6000 = 3'd6,
		TGT_PRG     = 3'd7
	} load_tgt_e;

	// One byte write towards the shared RAM/ROM port
	typedef struct packed {
		mem_addr_t addr;
		mem_byte_t data;
	} mem_wr_t;

	// ==============================
	// Engine control
	// ==============================
	typedef enum logic [1:0] {
		LDR_IDLE   = 2'd0,
		LDR_STREAM = 2'd1,
		LDR_INJECT = 2'd2,
		LDR_ERASE  = 2'd3
	} ldr_state_e;

	typedef logic [1:0] erase_mode_t;

	// Partial clears seg 15 bank 0 and video RAM, full clears all RAM first
	localparam erase_mode_t ERASE_NONE = 2'd0;
	localparam erase_mode_t ERASE_PART = 2'd1;
	localparam erase_mode_t ERASE_FULL = 2'd2;

endpackage

/* common/sys_pkg.sv */
/*
 * System configuration types of the CBM-II machine
 */
package sys_pkg;

	// ==============================
	// Model and RAM size
	// ==============================

	// P is the P500 line, B is the B6x0/B7x0 line
	typedef enum logic {
		MODEL_P = 1'b0,
		MODEL_B = 1'b1
	} model_e;

	typedef logic [1:0] ramsize_t;

	localparam ramsize_t RAM_128K = 2'd0;
	localparam ramsize_t RAM_256K = 2'd1;
	localparam ramsize_t RAM_896K = 2'd2;

	// ==============================
	// Configuration word
	// ==============================

	// profile: 0 for P or low profile, 1 for high profile
	// cpu2mhz: 0 for 1 MHz, 1 for 2 MHz
	// ntsc: 0 for PAL, 1 for NTSC
	typedef struct packed {
		model_e   model;
		logic     profile;
		ramsize_t ramsize;
		logic     cpu2mhz;
		logic     ntsc;
	} sys_cfg_t;

endpackage

/* hdl/cbm2_loader_top.sv */
/*
 * CBM-II memory loader top level
 * Host byte stream to writes on the shared RAM/ROM port
 */
module cbm2_loader_top (
	input  logic                  clk_sys,
	input  logic                  arst_n_i,

	// Host download stream
	input  mem_pkg::mem_byte_t    host_index_i,
	input  mem_pkg::host_addr_t   host_addr_i,
	input  mem_pkg::mem_byte_t    host_data_i,
	input  logic                  host_wr_i,
	input  logic                  host_download_i,
	input  logic [10:0]           status_i,
	output logic                  host_wait_o,

	// Erase start
	input  logic                  erase_req_i,
	input  mem_pkg::erase_mode_t  erase_mode_i,

	// Machine memory port
	input  logic                  io_cycle_i,
	output mem_pkg::mem_wr_t      mem_o,
	output logic                  mem_ce_o,
	output logic                  mem_we_o,

	output sys_pkg::sys_cfg_t     cfg_o,
	output logic [2:0]            extrom_o
);

	import mem_pkg::*;

	load_tgt_e tgt;
	mem_wr_t   wr_data;
	logic      wr_ack;

	cfg_decode u_cfg_decode (
		.status_i     (status_i),
		.host_index_i (host_index_i),
		.cfg_o        (cfg_o),
		.tgt_o        (tgt)
	);

	// Wait level is the pending request
	load_engine u_load_engine (
		.clk_sys         (clk_sys),
		.arst_n_i        (arst_n_i),
		.cfg_i           (cfg_o),
		.tgt_i           (tgt),
		.host_addr_i     (host_addr_i),
		.host_data_i     (host_data_i),
		.host_wr_i       (host_wr_i),
		.host_download_i (host_download_i),
		.erase_req_i     (erase_req_i),
		.erase_mode_i    (erase_mode_i),
		.wr_ack_i        (wr_ack),
		.wr_req_o        (host_wait_o),
		.wr_data_o       (wr_data),
		.extrom_o        (extrom_o)
	);

	mem_port u_mem_port (
		.clk_sys    (clk_sys),
		.arst_n_i   (arst_n_i),
		.io_cycle_i (io_cycle_i),
		.wr_req_i   (host_wait_o),
		.wr_data_i  (wr_data),
		.wr_ack_o   (wr_ack),
		.mem_o      (mem_o),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o)
	);

endmodule

/* hdl/cfg_decode.sv */
/*
 * Configuration decoder
 * Turns status bits into the system configuration and the host index into a load target
 */
module cfg_decode (
	input  logic [10:0]         status_i,
	input  mem_pkg::mem_byte_t  host_index_i,
	output sys_pkg::sys_cfg_t   cfg_o,
	output mem_pkg::load_tgt_e  tgt_o
);

	import sys_pkg::*;
	import mem_pkg::*;

	// Status layout
	//   [2:0]  preset: P500, B610, B620, B710, B720, Custom
	//   [4:3]  custom model: Professional, Business LP, Business HP
	//   [6:5]  reserved
	//   [8:7]  custom RAM size
	//   [9]    custom CPU clock
	//   [10]   TV system
	logic [2:0] preset;
	logic       cfg_custom;
	logic       is_p500;
	logic       is_7x0;
	logic       is_x10;

	assign preset     = status_i[2:0];
	assign cfg_custom = (preset == 3'd5);
	assign is_p500    = (preset == 3'd0);
	assign is_7x0     = (preset == 3'd3) || (preset == 3'd4);
	assign is_x10     = (preset == 3'd0) || (preset == 3'd1) || (preset == 3'd3);

	// ==============================
	// Preset or custom fields
	// ==============================
	always_comb begin
		if (cfg_custom) begin
			cfg_o.model   = (|status_i[4:3]) ? MODEL_B : MODEL_P;
			cfg_o.profile = status_i[4];
			cfg_o.ramsize = status_i[8:7];
			cfg_o.cpu2mhz = status_i[9];
		end else begin
			cfg_o.model   = is_p500 ? MODEL_P : MODEL_B;
			cfg_o.profile = is_7x0;
			cfg_o.ramsize = is_x10 ? RAM_128K : RAM_256K;
			cfg_o.cpu2mhz = !is_p500;
		end
		// B7x0 machines are always 60 Hz
		cfg_o.ntsc = status_i[10] | is_7x0;
	end

	// Index 0x00, 0x40 and 0x80 are the boot-time ROM slots
	always_comb begin
		case (host_index_i)
			8'h01, 8'h00: tgt_o = TGT_P500;
			8'h02, 8'h40: tgt_o = TGT_B6X0;
			8'h03, 8'h80: tgt_o = TGT_B7X0;
			8'h04:        tgt_o = TGT_EXT2000;
			8'h05:        tgt_o = TGT_EXT4000;
			8'h06:        tgt_o = TGT_EXT6000;
			8'h09:        tgt_o = TGT_PRG;
			default:      tgt_o = TGT_NONE;
		endcase
	end

endmodule

/* loader/load_engine.sv */
/*
 * Load engine
 * Address generator for ROM and PRG streaming, BASIC pointer injection and RAM erase
 */
`include "loader_cfg.svh"

module load_engine (
	input  logic                  clk_sys,
	input  logic                  arst_n_i,
	input  sys_pkg::sys_cfg_t     cfg_i,
	input  mem_pkg::load_tgt_e    tgt_i,
	input  mem_pkg::host_addr_t   host_addr_i,
	input  mem_pkg::mem_byte_t    host_data_i,
	input  logic                  host_wr_i,
	input  logic                  host_download_i,
	input  logic                  erase_req_i,
	input  mem_pkg::erase_mode_t  erase_mode_i,
	input  logic                  wr_ack_i,
	output logic                  wr_req_o,
	output mem_pkg::mem_wr_t      wr_data_o,
	output logic [2:0]            extrom_o
);

	import sys_pkg::*;
	import mem_pkg::*;

	ldr_state_e  state_q;
	logic        wr_req_q;
	erase_mode_t erase_pend_q;
	erase_mode_t erase_mode_q;
	logic [5:0]  gap_q;

	mem_addr_t   addr_q;
	mem_byte_t   data_q;
	logic [15:0] ptr_start_q;
	logic [15:0] ptr_end_q;

	mem_addr_t   tgt_base;
	host_addr_t  tgt_limit;
	mem_addr_t   next_addr;
	mem_addr_t   ram_top;
	mem_addr_t   full_base;
	logic [3:0]  top_bank;
	logic        top_valid;
	mem_byte_t   ptr_byte;
	logic        ptr_hit;

	logic        rom_tgt;
	logic        host_take;
	logic        byte_ok;
	logic        erase_start;
	logic        erase_fire;
	logic        inject_start;
	logic        inject_walk;

	// ==============================
	// Target decode
	// ==============================
	always_comb begin
		tgt_base  = `LDR_ROM_P500_BASE;
		tgt_limit = `LDR_SYS_ROM_LIMIT;
		case (tgt_i)
			TGT_B6X0: tgt_base = `LDR_ROM_B6X0_BASE;
			TGT_B7X0: tgt_base = `LDR_ROM_B7X0_BASE;
			TGT_EXT2000: begin
				tgt_base  = `LDR_EXT_BASE_2000;
				tgt_limit = `LDR_EXT_ROM_LIMIT;
			end
			TGT_EXT4000: begin
				tgt_base  = `LDR_EXT_BASE_4000;
				tgt_limit = `LDR_EXT_ROM_LIMIT;
			end
			TGT_EXT6000: begin
				tgt_base  = `LDR_EXT_BASE_6000;
				tgt_limit = `LDR_EXT_ROM_LIMIT;
			end
			default: ;
		endcase
	end

	assign rom_tgt = (tgt_i != TGT_NONE) && (tgt_i != TGT_PRG);

	// Strobes only count outside erase and injection
	assign host_take = host_wr_i && host_download_i && (erase_pend_q == ERASE_NONE)
		&& (state_q == LDR_IDLE || state_q == LDR_STREAM);

	// PRG bytes 0 and 1 are the load address, not data
	assign byte_ok = (rom_tgt && host_addr_i < tgt_limit)
		|| (tgt_i == TGT_PRG && host_addr_i >= host_addr_t'(2));

	assign erase_start  = (state_q == LDR_IDLE) && !wr_req_q && (erase_pend_q != ERASE_NONE);
	assign erase_fire   = (state_q == LDR_ERASE) && !wr_req_q
		&& (gap_q == 6'(`LDR_ERASE_GAP - 1));
	assign inject_start = (state_q == LDR_STREAM) && !host_download_i && !wr_req_q
		&& (tgt_i == TGT_PRG);
	assign inject_walk  = (state_q == LDR_INJECT) && !wr_req_q && !addr_q[8];

	// TXTTAB then TXTEND, low byte first
	always_comb begin
		ptr_hit  = 1'b1;
		ptr_byte = ptr_start_q[7:0];
		case (addr_q[7:0])
			`LDR_PTR_TXTTAB:         ptr_byte = ptr_start_q[7:0];
			8'(`LDR_PTR_TXTTAB + 1): ptr_byte = ptr_start_q[15:8];
			`LDR_PTR_TXTEND:         ptr_byte = ptr_end_q[7:0];
			8'(`LDR_PTR_TXTEND + 1): ptr_byte = ptr_end_q[15:8];
			default:                 ptr_hit  = 1'b0;
		endcase
	end

	// Top of RAM is bank 1..4, bank 0 of a B machine holds no RAM
	assign top_bank  = {2'b00, cfg_i.ramsize[0], 1'b0} + {3'b000, cfg_i.model == MODEL_B} + 4'd1;
	assign top_valid = (cfg_i.ramsize == RAM_128K) || (cfg_i.ramsize == RAM_256K);
	assign ram_top   = {5'd0, top_bank, 16'hFFFF};
	assign full_base = mem_addr_t'({cfg_i.model == MODEL_B, 16'h0000});

	always_comb begin
		next_addr = addr_q + 1'b1;
		if (state_q == LDR_ERASE) begin
			if (erase_mode_q == ERASE_FULL && top_valid && addr_q == ram_top)
				next_addr = `LDR_ZP_BASE;
			else if (addr_q == `LDR_VRAM_LO_END)
				next_addr = `LDR_VRAM_HI_BASE;
		end
	end

	// ==============================
	// Control state
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q      <= LDR_IDLE;
			wr_req_q     <= 1'b0;
			erase_pend_q <= ERASE_NONE;
			erase_mode_q <= ERASE_NONE;
			gap_q        <= '0;
			extrom_o     <= '0;
		end else begin
			if (wr_ack_i)
				wr_req_q <= 1'b0;
			else if ((host_take && byte_ok) || (inject_walk && ptr_hit) || erase_fire)
				wr_req_q <= 1'b1;

			if (erase_start) begin
				erase_mode_q <= erase_pend_q;
				erase_pend_q <= ERASE_NONE;
			end
			if (erase_req_i && erase_mode_i != ERASE_NONE)
				erase_pend_q <= erase_mode_i;

			if (erase_start || erase_fire)
				gap_q <= '0;
			else if (state_q == LDR_ERASE && !wr_req_q)
				gap_q <= gap_q + 1'b1;

			if (host_take) begin
				case (tgt_i)
					TGT_EXT2000: extrom_o[0] <= 1'b1;
					TGT_EXT4000: extrom_o[1] <= 1'b1;
					TGT_EXT6000: extrom_o[2] <= 1'b1;
					default: ;
				endcase
			end

			case (state_q)
				LDR_IDLE: begin
					if (erase_start)
						state_q <= LDR_ERASE;
					else if (host_download_i)
						state_q <= LDR_STREAM;
				end
				LDR_STREAM: begin
					if (!host_download_i && !wr_req_q)
						state_q <= (tgt_i == TGT_PRG) ? LDR_INJECT : LDR_IDLE;
				end
				LDR_INJECT: begin
					if (!wr_req_q && addr_q[8])
						state_q <= LDR_IDLE;
				end
				LDR_ERASE: begin
					if (wr_ack_i && addr_q == `LDR_VRAM_HI_END)
						state_q <= LDR_IDLE;
				end
				default: state_q <= LDR_IDLE;
			endcase
		end
	end

	// ==============================
	// Address and data
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (erase_start)
			addr_q <= (erase_pend_q == ERASE_FULL) ? full_base : `LDR_ZP_BASE;
		else if (inject_start)
			addr_q <= `LDR_ZP_BASE;
		else if (wr_ack_i)
			addr_q <= next_addr;
		else if (inject_walk && !ptr_hit)
			addr_q <= addr_q + 1'b1;
		else if (host_take && host_addr_i == '0) begin
			if (rom_tgt)
				addr_q <= tgt_base;
			else if (tgt_i == TGT_PRG) begin
				addr_q[24:16] <= (cfg_i.model == MODEL_B) ? 9'd1 : 9'd0;
				addr_q[7:0]   <= host_data_i;
			end
		end else if (host_take && tgt_i == TGT_PRG && host_addr_i == host_addr_t'(1))
			addr_q[15:8] <= host_data_i;

		if (host_take)
			data_q <= host_data_i;
		else if (inject_walk && ptr_hit)
			data_q <= ptr_byte;
		else if (erase_fire)
			data_q <= {8{addr_q[14] ^ addr_q[3] ^ addr_q[2]}};

		// End pointer counts the program bytes
		if (host_take && tgt_i == TGT_PRG) begin
			if (host_addr_i == '0) begin
				ptr_start_q[7:0] <= host_data_i;
				ptr_end_q[7:0]   <= host_data_i;
			end else if (host_addr_i == host_addr_t'(1)) begin
				ptr_start_q[15:8] <= host_data_i;
				ptr_end_q[15:8]   <= host_data_i;
			end else
				ptr_end_q <= ptr_end_q + 1'b1;
		end
	end

	assign wr_req_o  = wr_req_q;
	assign wr_data_o = '{addr: addr_q, data: data_q};

endmodule

/* loader/mem_port.sv */
/*
 * Memory write port
 * Issues the pending loader write in the machine I/O slot
 */
module mem_port (
	input  logic              clk_sys,
	input  logic              arst_n_i,
	input  logic              io_cycle_i,
	input  logic              wr_req_i,
	input  mem_pkg::mem_wr_t  wr_data_i,
	output logic              wr_ack_o,
	output mem_pkg::mem_wr_t  mem_o,
	output logic              mem_ce_o,
	output logic              mem_we_o
);

	logic io_cycle_q;
	logic slot_fall;
	logic slot_rise;

	// ==============================
	// Slot edges
	// ==============================
	assign slot_fall = io_cycle_q && !io_cycle_i;
	assign slot_rise = !io_cycle_q && io_cycle_i;

	// Request is taken at the start of the slot
	assign wr_ack_o = slot_fall && wr_req_i;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			io_cycle_q <= 1'b0;
			mem_ce_o   <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			io_cycle_q <= io_cycle_i;
			if (wr_ack_o) begin
				mem_ce_o <= 1'b1;
				mem_we_o <= 1'b1;
			end else if (slot_rise) begin
				mem_ce_o <= 1'b0;
				mem_we_o <= 1'b0;
			end
		end
	end

	// Address and data held for the whole slot
	always_ff @(posedge clk_sys) begin
		if (wr_ack_o)
			mem_o <= wr_data_i;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the loader testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_loader -Mdir "$OBJ" -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_loader" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
	exit 0
fi

echo "Pass line not found in $LOG"
exit 1

/* verification/loader_input.txt */
// Columns: opcode, argument A, argument B (hex). 1 status, 2 download index, 3 byte addr data,
// 4 end download, 5 erase mode top, 6 cfg, 7 mem addr data, 8 write count, 9 extrom, f end
1 0000000 00
6 0000000 00
1 0000001 00
6 0000022 00
1 0000002 00
6 0000026 00
1 0000003 00
6 0000033 00
1 0000004 00
6 0000037 00
1 0000515 00
6 0000039 00
// P500 with 128K from here on
1 0000000 00
// P500 system ROM, last byte past the image limit
2 0000001 00
3 0000000 a5
3 0000001 5a
3 0000002 3c
3 000b000 77
4 0000000 00
8 0000003 00
7 1020000 a5
7 1020001 5a
7 1020002 3c
9 0000000 00
// External ROM at 0x4000, two bytes past the limit
2 0000005 00
3 0000000 11
3 0000001 22
3 0002000 33
3 0002001 44
4 0000000 00
8 0000002 00
7 1034000 11
7 1034001 22
9 0000002 00
// PRG at 0x0401 with three bytes, then TXTTAB and TXTEND
2 0000009 00
3 0000000 01
3 0000001 04
3 0000002 aa
3 0000003 bb
3 0000004 cc
4 0000000 00
8 0000007 00
7 0000401 aa
7 0000403 cc
7 00f002d 01
7 00f002e 04
7 00f002f 04
7 00f0030 04
// Partial erase
5 0000001 0000000
8 0001800 00
7 00f0000 00
7 00f002d 00
7 00fd7ff ff
// Full erase up to 0x1FFFF
5 0000002 001ffff
8 0021800 00
7 0000401 00
7 0004008 00
7 001400c ff
7 001ffff ff
7 00fd000 ff
7 1020000 a5
f 0000000 00

/* verification/tb_loader.sv */
/*
 * Testbench of the CBM-II memory loader
 * Runs a command script against a byte model of the RAM/ROM port
 */
`include "loader_cfg.svh"

module tb_loader;

	import sys_pkg::*;
	import mem_pkg::*;

	localparam int SCRIPT_WORDS = 256;
	localparam int BYTE_WAIT    = 100;
	localparam int WRITE_WAIT   = 200;
	localparam int COUNT_WAIT   = 20000;
	localparam int QUIET_CYCLES = 320;

	// Each script command is an opcode and two arguments
	localparam logic [27:0] OP_STATUS   = 28'h1;
	localparam logic [27:0] OP_DOWNLOAD = 28'h2;
	localparam logic [27:0] OP_BYTE     = 28'h3;
	localparam logic [27:0] OP_END_DL   = 28'h4;
	localparam logic [27:0] OP_ERASE    = 28'h5;
	localparam logic [27:0] OP_CFG      = 28'h6;
	localparam logic [27:0] OP_MEM      = 28'h7;
	localparam logic [27:0] OP_COUNT    = 28'h8;
	localparam logic [27:0] OP_EXTROM   = 28'h9;
	localparam logic [27:0] OP_END      = 28'hF;

	logic         clk_sys;
	logic         arst_n;
	mem_byte_t    host_index;
	host_addr_t   host_addr;
	mem_byte_t    host_data;
	logic         host_wr;
	logic         host_download;
	logic [10:0]  status;
	logic         host_wait;
	logic         erase_req;
	erase_mode_t  erase_mode;
	mem_wr_t      mem_bus;
	logic         mem_ce;
	logic         mem_we;
	sys_cfg_t     cfg;
	logic [2:0]   extrom;

	logic [27:0]  script [0:SCRIPT_WORDS-1];
	int unsigned  count_mark;

	// Memory model and write monitor
	mem_byte_t    mem_model [mem_addr_t];
	mem_wr_t      last_wr;
	int unsigned  wr_count = 0;
	logic         we_q = 1'b0;

	// I/O slot of the machine
	logic [1:0]   io_div = 2'd0;
	logic         io_cycle = 1'b0;

	cbm2_loader_top DUT (
		.clk_sys         (clk_sys),
		.arst_n_i        (arst_n),
		.host_index_i    (host_index),
		.host_addr_i     (host_addr),
		.host_data_i     (host_data),
		.host_wr_i       (host_wr),
		.host_download_i (host_download),
		.status_i        (status),
		.host_wait_o     (host_wait),
		.erase_req_i     (erase_req),
		.erase_mode_i    (erase_mode),
		.io_cycle_i      (io_cycle),
		.mem_o           (mem_bus),
		.mem_ce_o        (mem_ce),
		.mem_we_o        (mem_we),
		.cfg_o           (cfg),
		.extrom_o        (extrom)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	// Slot level toggles every 4 clocks
	always @(negedge clk_sys) begin
		if (!arst_n) begin
			io_div   <= 2'd0;
			io_cycle <= 1'b0;
		end else begin
			io_div <= io_div + 2'd1;
			if (io_div == 2'd3)
				io_cycle <= ~io_cycle;
		end
	end

	// One write per rising edge of the write enable
	always @(negedge clk_sys) begin
		if (mem_we && !we_q) begin
			assert (mem_ce)
				else value_error("mem_ce_o", 32'(mem_ce), 32'd1);
			mem_model[mem_bus.addr] = mem_bus.data;
			last_wr  = mem_bus;
			wr_count = wr_count + 1;
		end
		we_q = mem_we;
	end

	// ==============================
	// Reporting
	// ==============================
	task automatic stop_run;
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		stop_run();
	endtask

	task automatic text_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		stop_run();
	endtask

	// Odd parity of address bits 14, 3 and 2 gives an all-ones byte
	function automatic mem_byte_t fill_byte(input mem_addr_t addr);
		return (addr[14] ^ addr[3] ^ addr[2]) ? 8'hFF : 8'h00;
	endfunction

	// ==============================
	// Host and erase stimulus
	// ==============================
	task automatic send_byte(input host_addr_t addr, input mem_byte_t data);
		int n;
		n = 0;
		@(negedge clk_sys);
		// No strobe while a write is still pending
		while (host_wait) begin
			@(negedge clk_sys);
			n = n + 1;
			if (n > BYTE_WAIT)
				text_error("wait level stayed high during a download");
		end
		host_addr = addr;
		host_data = data;
		host_wr   = 1'b1;
		@(negedge clk_sys);
		host_wr   = 1'b0;
	endtask

	task automatic wait_write(input int unsigned seen);
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n = n + 1;
			if (n > WRITE_WAIT)
				text_error("erase write missing after the erase spacing");
		end while (wr_count == seen);
	endtask

	// Follows every erase write through its expected address sequence
	task automatic run_erase(input erase_mode_t mode, input mem_addr_t top);
		mem_addr_t   exp_addr;
		int unsigned seen;
		logic        done;
		// P machines start in bank 0 and top out in an odd bank
		if (mode == ERASE_FULL)
			exp_addr = {8'd0, !top[16], 16'h0000};
		else
			exp_addr = `LDR_ZP_BASE;
		done = 1'b0;
		@(posedge clk_sys);
		seen = wr_count;
		@(negedge clk_sys);
		erase_req  = 1'b1;
		erase_mode = mode;
		@(negedge clk_sys);
		erase_req  = 1'b0;
		while (!done) begin
			wait_write(seen);
			seen = wr_count;
			assert (last_wr.addr == exp_addr)
				else value_error("mem_o.addr", 32'(last_wr.addr), 32'(exp_addr));
			assert (last_wr.data == fill_byte(exp_addr))
				else value_error("mem_o.data", 32'(last_wr.data), 32'(fill_byte(exp_addr)));
			if (mode == ERASE_FULL && exp_addr == top)
				exp_addr = `LDR_ZP_BASE;
			else if (exp_addr == `LDR_VRAM_LO_END)
				exp_addr = `LDR_VRAM_HI_BASE;
			else if (exp_addr == `LDR_VRAM_HI_END)
				done = 1'b1;
			else
				exp_addr = exp_addr + 25'd1;
		end
	endtask

	// ==============================
	// Checks
	// ==============================
	task automatic verify_count(input logic [27:0] exp_cnt);
		int n;
		n = 0;
		do begin
			@(posedge clk_sys);
			n = n + 1;
			if (n > COUNT_WAIT)
				text_error($sformatf("only %0d of %0d expected writes arrived",
					wr_count - count_mark, exp_cnt));
		end while (wr_count - count_mark < 32'(exp_cnt));
		// Quiet window catches writes beyond the expected number
		repeat (QUIET_CYCLES) @(posedge clk_sys);
		assert (wr_count - count_mark == 32'(exp_cnt))
			else value_error("write count", wr_count - count_mark, 32'(exp_cnt));
		count_mark = wr_count;
	endtask

	task automatic check_mem(input mem_addr_t addr, input mem_byte_t exp);
		@(posedge clk_sys);
		assert (mem_model.exists(addr))
			else text_error($sformatf("no write ever reached address %h", addr));
		assert (mem_model[addr] == exp)
			else value_error($sformatf("mem[%h]", addr), 32'(mem_model[addr]), 32'(exp));
	endtask

	// ==============================
	// Script runner
	// ==============================
	initial begin
		int          pc;
		logic [27:0] op;
		logic [27:0] arg_a;
		logic [27:0] arg_b;
		logic        running;

		arst_n        = 1'b0;
		host_index    = '0;
		host_addr     = '0;
		host_data     = '0;
		host_wr       = 1'b0;
		host_download = 1'b0;
		status        = '0;
		erase_req     = 1'b0;
		erase_mode    = ERASE_NONE;
		count_mark    = 0;
		$readmemh("verification/loader_input.txt", script);

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;
		@(posedge clk_sys);
		assert (!mem_ce)
			else value_error("mem_ce_o", 32'(mem_ce), 32'd0);
		assert (!mem_we)
			else value_error("mem_we_o", 32'(mem_we), 32'd0);
		assert (!host_wait)
			else value_error("host_wait_o", 32'(host_wait), 32'd0);
		assert (extrom == 3'b000)
			else value_error("extrom_o", 32'(extrom), 32'd0);

		pc      = 0;
		running = 1'b1;
		while (running) begin
			if (pc + 3 > SCRIPT_WORDS)
				text_error("command script has no end marker");
			op    = script[pc];
			arg_a = script[pc + 1];
			arg_b = script[pc + 2];
			pc    = pc + 3;
			case (op)
				OP_STATUS: begin
					@(negedge clk_sys);
					status = arg_a[10:0];
				end
				OP_DOWNLOAD: begin
					@(negedge clk_sys);
					host_index    = arg_a[7:0];
					host_download = 1'b1;
				end
				OP_BYTE: send_byte(arg_a[24:0], arg_b[7:0]);
				OP_END_DL: begin
					@(negedge clk_sys);
					host_download = 1'b0;
				end
				OP_ERASE: run_erase(arg_a[1:0], arg_b[24:0]);
				OP_CFG: begin
					@(posedge clk_sys);
					assert (28'(cfg) == arg_a)
						else value_error("cfg_o", 32'(cfg), 32'(arg_a));
				end
				OP_MEM: check_mem(arg_a[24:0], arg_b[7:0]);
				OP_COUNT: verify_count(arg_a);
				OP_EXTROM: begin
					@(posedge clk_sys);
					assert (extrom == arg_a[2:0])
						else value_error("extrom_o", 32'(extrom), 32'(arg_a));
				end
				OP_END: running = 1'b0;
				default: text_error($sformatf("unknown command %h at script word %0d",
					op, pc - 3));
			endcase
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
common/sys_pkg.sv
common/mem_pkg.sv
hdl/cfg_decode.sv
loader/load_engine.sv
loader/mem_port.sv
hdl/cbm2_loader_top.sv
verification/tb_loader.sv
